// File: include/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split is tag 31..11, index 10..6, offset 5..0
`define CACHE_ADDR_WIDTH    32
`define CACHE_DATA_WIDTH    64
`define CACHE_ROW_WIDTH     128
`define CACHE_INDEX_WIDTH   5
`define CACHE_SETS          32
`define CACHE_OFFSET_WIDTH  6
`define CACHE_TAG_WIDTH     21

`define CACHE_WAYS          2
`define CACHE_ROWS_PER_LINE 4  // 64-byte line of 128-bit rows
`define CACHE_BURST_BEATS   8  // 64-bit beats per line

`endif

// File: list.f
+incdir+include
verilog/cache_pkg.sv
verilog/cache_tag_store.sv
verilog/cache_data_array.sv
verilog/cache_controller.sv
verilog/cache_top.sv
test/tb_mem_model.sv
test/tb_cache.sv

// File: test/tb_cache.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module tb_cache;

  localparam int RANDOM_OPS  = 200;
  localparam int TOTAL_REQ   = 16 + 16 + 4 + 32 + RANDOM_OPS;
  localparam int MISS_CYCLES = 4 * (2 * (`CACHE_BURST_BEATS + 1) + 4);  // two bursts, stall margin
  localparam int SPACE       = 65536;  // tests stay in the low 64 KiB

  logic                    clk;
  logic                    rst;
  logic                    rw_addr_valid;
  logic                    rw_addr_ready;
  cache_pkg::addr_t        rw_addr;
  logic                    rw_we;
  cache_pkg::access_size_t rw_size;
  cache_pkg::data_t        w_data;
  logic                    rw_done;
  cache_pkg::data_t        r_data;
  logic                    mem_req_valid;
  logic                    mem_req_ready;
  cache_pkg::addr_t        mem_req_addr;
  logic                    mem_req_we;
  logic                    mem_w_valid;
  logic                    mem_w_ready;
  cache_pkg::data_t        mem_w_data;
  logic                    mem_r_valid;
  logic                    mem_r_ready;
  cache_pkg::data_t        mem_r_data;

  logic [7:0]              shadow [SPACE];
  integer                  seed;
  int                      checks;
  int                      errors;
  int                      errors_mark;
  int                      wb_bursts;
  logic                    accept_q;
  logic                    req_wait_q;
  cache_pkg::addr_t        req_addr_q;
  logic                    req_we_q;
  cache_pkg::data_t        load_exp;

  cache_top i_dut (
    .clk             (clk),
    .rst             (rst),
    .rw_addr_valid_i (rw_addr_valid),
    .rw_addr_ready_o (rw_addr_ready),
    .rw_addr_i       (rw_addr),
    .rw_we_i         (rw_we),
    .rw_size_i       (rw_size),
    .w_data_i        (w_data),
    .rw_done_o       (rw_done),
    .r_data_o        (r_data),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_we_o    (mem_req_we),
    .mem_w_valid_o   (mem_w_valid),
    .mem_w_ready_i   (mem_w_ready),
    .mem_w_data_o    (mem_w_data),
    .mem_r_valid_i   (mem_r_valid),
    .mem_r_ready_o   (mem_r_ready),
    .mem_r_data_i    (mem_r_data)
  );

  tb_mem_model i_mem (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .req_addr_i  (mem_req_addr),
    .req_we_i    (mem_req_we),
    .w_valid_i   (mem_w_valid),
    .w_ready_o   (mem_w_ready),
    .w_data_i    (mem_w_data),
    .r_valid_o   (mem_r_valid),
    .r_ready_i   (mem_r_ready),
    .r_data_o    (mem_r_data)
  );

  always #50 clk = ~clk;

  // same fill pattern as the memory model
  function automatic cache_pkg::data_t initial_word(cache_pkg::addr_t a);
    return {a ^ 32'hc3a5_5a3c, ~a};
  endfunction

  // bytes from a upward packed down to bit 0, upper bits zero
  function automatic cache_pkg::data_t expected_load(cache_pkg::addr_t a,
                                                     cache_pkg::access_size_t s);
    cache_pkg::data_t v;
    int               i;
    v = '0;
    for (i = 0; i < (1 << s); i++) begin
      v[i*8 +: 8] = shadow[a[15:0] + i];
    end
    return v;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    $display("%s finished with %0d errors", name, errors - errors_mark);
    errors_mark = errors;
  endtask

  // starts 5 ns after an edge, holds the request until done, ends the same way
  task automatic run_request(input cache_pkg::addr_t addr, input logic we,
                             input cache_pkg::access_size_t size,
                             input cache_pkg::data_t data, output int mem_reqs);
    int i;
    mem_reqs      = 0;
    rw_addr_valid = 1'b1;
    rw_addr       = addr;
    rw_we         = we;
    rw_size       = size;
    w_data        = data;
    do begin
      @(negedge clk);
      if (mem_req_valid) begin
        mem_reqs++;
      end
    end while (!rw_done);
    if (we) begin
      for (i = 0; i < (1 << size); i++) begin
        shadow[addr[15:0] + i] = data[i*8 +: 8];
      end
    end
    @(posedge clk);
    #5;
    rw_addr_valid = 1'b0;
  endtask

  // load compare and completion timing
  always @(negedge clk) begin
    if (!rst && rw_done) begin
      checks++;
      if (!accept_q) begin
        flag_error("completion without an acceptance one cycle earlier");
      end
      if (rw_addr_ready) begin
        flag_error("rw_addr_ready_o high in the completion cycle");
      end
      if (!rw_we) begin
        load_exp = expected_load(rw_addr, rw_size);
        if (r_data !== load_exp) begin
          flag_error($sformatf("load %h size %0d returned %h, expected %h",
                               rw_addr, rw_size, r_data, load_exp));
        end
      end
    end
    accept_q = rw_addr_valid && rw_addr_ready;
  end

  always @(negedge clk) begin
    if (req_wait_q && (!mem_req_valid || mem_req_addr !== req_addr_q ||
                       mem_req_we !== req_we_q)) begin
      flag_error("memory request changed while waiting for ready");
    end
    if (mem_req_valid && mem_req_ready && mem_req_we) begin
      wb_bursts++;
    end
    req_wait_q = mem_req_valid && !mem_req_ready;
    req_addr_q = mem_req_addr;
    req_we_q   = mem_req_we;
  end

  initial begin
    #(TOTAL_REQ * MISS_CYCLES * 100);
    $display("watchdog expired, the DUT stopped completing requests");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int               i;
    int               k;
    int               s;
    int               reqs;
    int               wb_before;
    logic             we_bit;
    cache_pkg::addr_t a;
    cache_pkg::data_t d;
    clk           = 1'b0;
    rst           = 1'b1;
    rw_addr_valid = 1'b0;
    rw_addr       = '0;
    rw_we         = 1'b0;
    rw_size       = cache_pkg::SIZE_1B;
    w_data        = '0;
    seed          = 32'h26841c7d;
    checks        = 0;
    errors        = 0;
    errors_mark   = 0;
    wb_bursts     = 0;
    accept_q      = 1'b0;
    req_wait_q    = 1'b0;
    req_addr_q    = '0;
    req_we_q      = 1'b0;
    for (i = 0; i < SPACE; i++) begin
      d         = initial_word(cache_pkg::addr_t'(i & ~7));
      shadow[i] = d[(i % 8) * 8 +: 8];
    end
    repeat (3) @(posedge clk);
    #5;
    rst = 1'b0;

    @(negedge clk);
    checks++;
    if (rw_addr_ready !== 1'b1 || rw_done !== 1'b0 || mem_req_valid !== 1'b0 ||
        mem_w_valid !== 1'b0 || mem_r_ready !== 1'b0) begin
      flag_error("outputs after reset are not idle");
    end
    end_test("reset");
    @(posedge clk);
    #5;

    for (s = 0; s < 4; s++) begin
      for (k = 0; k < 4; k++) begin
        a = 32'h0000_4000 + (s * 4 + k) * 64 + (((k * 21 + 3) % 64) & ~((1 << s) - 1));
        run_request(a, 1'b0, cache_pkg::access_size_t'(s), '0, reqs);
      end
    end
    end_test("uncached loads");

    for (s = 0; s < 4; s++) begin
      a = 32'h0000_2040 + s * 16 + (1 << s);
      d = {$random(seed), $random(seed)};
      run_request(a, 1'b1, cache_pkg::access_size_t'(s), d, reqs);
      run_request(a & ~32'h7, 1'b0, cache_pkg::SIZE_8B, '0, reqs);
      run_request(a, 1'b0, cache_pkg::access_size_t'(s), '0, reqs);
      run_request(a, 1'b0, cache_pkg::SIZE_1B, '0, reqs);
    end
    end_test("store merge");

    for (k = 0; k < 2; k++) begin
      a = 32'h0000_3080 + k * 64;
      run_request(a, 1'b0, cache_pkg::SIZE_4B, '0, reqs);
      run_request(a + 8, 1'b0, cache_pkg::SIZE_8B, '0, reqs);
      checks++;
      if (reqs != 0) begin
        flag_error("second access to a cached line went to memory");
      end
    end
    end_test("hit latency");

    wb_before = wb_bursts;
    for (s = 0; s < 4; s++) begin
      for (k = 0; k < 4; k++) begin
        a = ((16 + s) << 11) | (20 << 6) | (k * 16 + 8);  // four tags, one set
        d = {$random(seed), $random(seed)};
        run_request(a, 1'b1, cache_pkg::SIZE_8B, d, reqs);
      end
    end
    for (s = 0; s < 4; s++) begin
      for (k = 0; k < 4; k++) begin
        a = ((16 + s) << 11) | (20 << 6) | (k * 16 + 8);
        run_request(a, 1'b0, cache_pkg::SIZE_8B, '0, reqs);
      end
    end
    checks++;
    if (wb_bursts - wb_before < 2) begin
      flag_error("set conflicts caused fewer than two dirty write-backs");
    end
    end_test("evictions");

    for (i = 0; i < RANDOM_OPS; i++) begin
      s      = $random(seed) & 3;
      a      = 32'h0000_c000 + 2048 * ($random(seed) & 3);
      a      = a + 64 * ($random(seed) & 3);
      a      = a + (($random(seed) & 63) & ~((1 << s) - 1));
      we_bit = ($random(seed) & 1) != 0;
      d      = {$random(seed), $random(seed)};
      run_request(a, we_bit, cache_pkg::access_size_t'(s), d, reqs);
    end
    end_test("random mix");

    $display("%0d checks, %0d errors, %0d write-back bursts", checks, errors, wb_bursts);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: test/tb_mem_model.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module tb_mem_model (
  input  logic             clk,
  input  logic             rst,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  cache_pkg::addr_t req_addr_i,
  input  logic             req_we_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  input  cache_pkg::data_t w_data_i,
  output logic             r_valid_o,
  input  logic             r_ready_i,
  output cache_pkg::data_t r_data_o
);

  localparam int WORDS = 8192;  // 64 KiB window

  cache_pkg::data_t words [WORDS];
  integer           seed;
  logic             busy;
  logic             we_q;
  cache_pkg::addr_t base_q;
  int               beat;
  logic             req_fire;
  logic             w_fire;
  logic             r_fire;
  cache_pkg::addr_t req_addr_s;
  logic             req_we_s;
  cache_pkg::data_t w_data_s;

  function automatic cache_pkg::data_t initial_word(cache_pkg::addr_t a);
    return {a ^ 32'hc3a5_5a3c, ~a};
  endfunction

  function automatic int word_index(cache_pkg::addr_t a);
    return int'(a[15:3]);
  endfunction

  function automatic logic no_stall();
    return ($random(seed) & 3) != 0;  // ready three times in four
  endfunction

  initial begin
    seed        = 32'h26841c7d;
    busy        = 1'b0;
    we_q        = 1'b0;
    base_q      = '0;
    beat        = 0;
    req_ready_o = 1'b0;
    w_ready_o   = 1'b0;
    r_valid_o   = 1'b0;
    r_data_o    = '0;
    for (int i = 0; i < WORDS; i++) begin
      words[i] = initial_word(cache_pkg::addr_t'(i * 8));
    end
  end

  // handshakes sampled at the edge, responses driven 5 ns later
  always @(posedge clk) begin
    req_fire   = req_valid_i && req_ready_o;
    w_fire     = w_valid_i && w_ready_o;
    r_fire     = r_valid_o && r_ready_i;
    req_addr_s = req_addr_i;
    req_we_s   = req_we_i;
    w_data_s   = w_data_i;
    #5;
    if (rst) begin
      busy        = 1'b0;
      beat        = 0;
      req_ready_o = 1'b0;
      w_ready_o   = 1'b0;
      r_valid_o   = 1'b0;
    end else begin
      if (req_fire) begin
        busy   = 1'b1;
        we_q   = req_we_s;
        base_q = req_addr_s;
        beat   = 0;
      end
      if (w_fire) begin
        words[word_index(base_q) + beat] = w_data_s;
        beat++;
      end
      if (r_fire) begin
        beat++;
      end
      if (beat == `CACHE_BURST_BEATS) begin
        busy = 1'b0;
        beat = 0;
      end
      req_ready_o = !busy && no_stall();
      w_ready_o   = busy && we_q && no_stall();
      if (!busy || we_q) begin
        r_valid_o = 1'b0;
      end else if (!r_valid_o || r_fire) begin
        r_valid_o = no_stall();  // held once raised
      end
      r_data_o = words[word_index(base_q) + beat];
    end
  end

endmodule

// File: verilog/cache_controller.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_controller (
  input  logic                    clk,
  input  logic                    rst,
  // processor side
  input  logic                    rw_addr_valid_i,
  output logic                    rw_addr_ready_o,
  input  cache_pkg::addr_t        rw_addr_i,
  input  logic                    rw_we_i,
  input  cache_pkg::access_size_t rw_size_i,
  input  cache_pkg::data_t        w_data_i,
  output logic                    rw_done_o,
  output cache_pkg::data_t        r_data_o,
  // memory side
  output logic                    mem_req_valid_o,
  input  logic                    mem_req_ready_i,
  output cache_pkg::addr_t        mem_req_addr_o,
  output logic                    mem_req_we_o,
  output logic                    mem_w_valid_o,
  input  logic                    mem_w_ready_i,
  output cache_pkg::data_t        mem_w_data_o,
  input  logic                    mem_r_valid_i,
  output logic                    mem_r_ready_o,
  input  cache_pkg::data_t        mem_r_data_i,
  // tag store
  output cache_pkg::index_t       lookup_index_o,
  output cache_pkg::tag_t         lookup_tag_o,
  input  logic                    hit_i,
  input  cache_pkg::way_t         hit_way_i,
  output cache_pkg::way_t         victim_way_o,
  input  logic                    victim_dirty_i,
  input  cache_pkg::tag_t         victim_tag_i,
  output logic                    set_dirty_o,
  output cache_pkg::way_t         set_way_o,
  output logic                    fill_start_o,
  output logic                    fill_done_o,
  output cache_pkg::tag_t         fill_tag_o,
  output logic                    clean_o,
  // data array
  output logic [$clog2(`CACHE_SETS*`CACHE_ROWS_PER_LINE)-1:0] row_addr_o,
  output cache_pkg::way_t         way_o,
  output logic                    we_o,
  output logic                    fill_o,
  output cache_pkg::data_t        store_data_o,
  output cache_pkg::data_t        fill_data_o,
  output logic                    fill_half_o,
  output cache_pkg::access_size_t size_o,
  output logic [3:0]              byte_offset_o,
  input  cache_pkg::row_t         row_i,
  input  cache_pkg::data_t        load_data_i
);

  localparam int TAG_LSB  = `CACHE_ADDR_WIDTH - `CACHE_TAG_WIDTH;
  localparam int ROW_LSB  = $clog2(`CACHE_ROW_WIDTH / 8);
  localparam int ROWSEL_W = $bits(cache_pkg::row_sel_t);

  cache_pkg::ctrl_state_t                state;
  cache_pkg::addr_t                      line_q;  // base of the missing line
  cache_pkg::way_t                       way_q;
  cache_pkg::way_t                       victim_cnt;
  logic [$clog2(`CACHE_BURST_BEATS)-1:0] beat_cnt;
  logic                                  rd_wait;
  cache_pkg::addr_t                      cur_addr;
  cache_pkg::row_sel_t                   row_sel;
  logic                                  idle;
  logic                                  accept;
  logic                                  w_fire;
  logic                                  r_fire;
  logic                                  last_beat;

  assign idle      = (state == cache_pkg::IDLE);
  assign accept    = rw_addr_valid_i && rw_addr_ready_o;
  assign w_fire    = mem_w_valid_o && mem_w_ready_i;
  assign r_fire    = mem_r_valid_i && mem_r_ready_o;
  assign last_beat = (beat_cnt == `CACHE_BURST_BEATS - 1);

  // lookup follows the live request in IDLE, the latched line otherwise
  assign cur_addr       = idle ? rw_addr_i : line_q;
  assign lookup_index_o = cur_addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
  assign lookup_tag_o   = cur_addr[TAG_LSB +: `CACHE_TAG_WIDTH];
  assign fill_tag_o     = lookup_tag_o;
  assign victim_way_o   = idle ? victim_cnt : way_q;

  assign set_dirty_o  = accept && hit_i && rw_we_i;
  assign set_way_o    = hit_way_i;
  assign clean_o      = w_fire && last_beat;
  assign fill_start_o = (accept && !hit_i && !victim_dirty_i) || clean_o;
  assign fill_done_o  = r_fire && last_beat;

  assign rw_addr_ready_o = idle;
  assign rw_done_o       = (state == cache_pkg::RESP);
  assign r_data_o        = load_data_i;  // read issued at acceptance

  assign mem_req_valid_o = (state == cache_pkg::WB_REQ) || (state == cache_pkg::FILL_REQ);
  assign mem_req_we_o    = (state == cache_pkg::WB_REQ);
  assign mem_req_addr_o  = mem_req_we_o ?
                           {victim_tag_i, lookup_index_o, {`CACHE_OFFSET_WIDTH{1'b0}}} : line_q;

  // hold off while the next row is still being read
  assign mem_w_valid_o = (state == cache_pkg::WB_DATA) && !rd_wait;
  assign mem_w_data_o  = row_i[beat_cnt[0] * `CACHE_DATA_WIDTH +: `CACHE_DATA_WIDTH];
  assign mem_r_ready_o = (state == cache_pkg::FILL_DATA);

  // two beats per row
  assign row_sel    = idle ? rw_addr_i[ROW_LSB +: ROWSEL_W] : cache_pkg::row_sel_t'(beat_cnt >> 1);
  assign row_addr_o = {lookup_index_o, row_sel};
  assign way_o      = idle ? hit_way_i : way_q;
  assign we_o       = set_dirty_o;
  assign fill_o     = r_fire;
  assign fill_half_o   = beat_cnt[0];
  assign store_data_o  = w_data_i;
  assign fill_data_o   = mem_r_data_i;
  assign size_o        = rw_size_i;
  assign byte_offset_o = rw_addr_i[ROW_LSB-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cache_pkg::IDLE;
      victim_cnt <= '0;
      beat_cnt   <= '0;
      rd_wait    <= 1'b0;
    end else begin
      victim_cnt <= victim_cnt + 1'b1;    // free-running replacement
      rd_wait    <= w_fire && beat_cnt[0];
      case (state)
        cache_pkg::IDLE: begin
          if (accept) begin
            beat_cnt <= '0;
            if (hit_i) begin
              state <= cache_pkg::RESP;
            end else if (victim_dirty_i) begin
              state <= cache_pkg::WB_REQ;
            end else begin
              state <= cache_pkg::FILL_REQ;
            end
          end
        end
        cache_pkg::RESP: state <= cache_pkg::IDLE;
        cache_pkg::WB_REQ: begin
          if (mem_req_ready_i) begin
            state <= cache_pkg::WB_DATA;
          end
        end
        cache_pkg::WB_DATA: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;  // wraps to 0 for the refill
            if (last_beat) begin
              state <= cache_pkg::FILL_REQ;
            end
          end
        end
        cache_pkg::FILL_REQ: begin
          if (mem_req_ready_i) begin
            state <= cache_pkg::FILL_DATA;
          end
        end
        cache_pkg::FILL_DATA: begin
          if (r_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= cache_pkg::IDLE;  // request retried as a hit
            end
          end
        end
        default: state <= cache_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !hit_i) begin
      line_q <= {rw_addr_i[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH], {`CACHE_OFFSET_WIDTH{1'b0}}};
      way_q  <= victim_cnt;
    end
  end

endmodule

// File: verilog/cache_data_array.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_data_array (
  input  logic                                              clk,
  input  logic [$clog2(`CACHE_SETS*`CACHE_ROWS_PER_LINE)-1:0] row_addr_i,  // {index, row_sel}
  input  cache_pkg::way_t                                   way_i,
  input  logic                                              we_i,
  input  logic                                              fill_i,
  input  cache_pkg::data_t                                  store_data_i,
  input  cache_pkg::data_t                                  fill_data_i,
  input  logic                                              fill_half_i,
  input  cache_pkg::access_size_t                           size_i,
  input  logic [3:0]                                        byte_offset_i,
  output cache_pkg::row_t                                   row_o,
  output cache_pkg::data_t                                  load_data_o
);

  localparam int ROW_BYTES  = `CACHE_ROW_WIDTH / 8;
  localparam int HALF_BYTES = ROW_BYTES / 2;
  localparam int DATA_BYTES = `CACHE_DATA_WIDTH / 8;
  localparam int DEPTH      = `CACHE_SETS * `CACHE_ROWS_PER_LINE;

  logic [ROW_BYTES-1:0]    wr_be;
  cache_pkg::row_t         wr_data;
  cache_pkg::row_t         rd_q [`CACHE_WAYS];
  cache_pkg::way_t         way_q;
  cache_pkg::access_size_t size_q;
  logic [3:0]              offset_q;
  cache_pkg::row_t         shifted;
  cache_pkg::data_t        load_mask;
  logic [DATA_BYTES-1:0]   load_be;

  function automatic logic [DATA_BYTES-1:0] size_mask(cache_pkg::access_size_t size);
    case (size)
      cache_pkg::SIZE_1B: size_mask = DATA_BYTES'(8'h01);
      cache_pkg::SIZE_2B: size_mask = DATA_BYTES'(8'h03);
      cache_pkg::SIZE_4B: size_mask = DATA_BYTES'(8'h0f);
      default:            size_mask = '1;
    endcase
  endfunction

  always_comb begin
    if (fill_i) begin
      wr_be   = {{HALF_BYTES{fill_half_i}}, {HALF_BYTES{~fill_half_i}}};
      wr_data = {fill_data_i, fill_data_i};
    end else begin
      // store lands at its byte offset within the row
      wr_be   = ROW_BYTES'(size_mask(size_i)) << byte_offset_i;
      wr_data = cache_pkg::row_t'(store_data_i) << {byte_offset_i, 3'b000};
    end
  end

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    cache_pkg::row_t mem [DEPTH];

    always_ff @(posedge clk) begin
      if ((we_i || fill_i) && (way_i == w)) begin
        for (int b = 0; b < ROW_BYTES; b++) begin
          if (wr_be[b]) begin
            mem[row_addr_i][b*8 +: 8] <= wr_data[b*8 +: 8];
          end
        end
      end
      rd_q[w] <= mem[row_addr_i];  // read-first
    end
  end

  always_ff @(posedge clk) begin
    way_q    <= way_i;
    size_q   <= size_i;
    offset_q <= byte_offset_i;
  end

  assign row_o   = rd_q[way_q];
  assign shifted = row_o >> {offset_q, 3'b000};
  assign load_be = size_mask(size_q);

  always_comb begin
    for (int b = 0; b < DATA_BYTES; b++) begin
      load_mask[b*8 +: 8] = {8{load_be[b]}};
    end
  end

  assign load_data_o = shifted[`CACHE_DATA_WIDTH-1:0] & load_mask;  // zero-extend

endmodule

// File: verilog/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_WIDTH-1:0]            addr_t;
  typedef logic [`CACHE_DATA_WIDTH-1:0]            data_t;
  typedef logic [`CACHE_ROW_WIDTH-1:0]             row_t;
  typedef logic [`CACHE_TAG_WIDTH-1:0]             tag_t;
  typedef logic [`CACHE_INDEX_WIDTH-1:0]           index_t;
  typedef logic [$clog2(`CACHE_WAYS)-1:0]          way_t;
  typedef logic [$clog2(`CACHE_ROWS_PER_LINE)-1:0] row_sel_t;  // address bits 5..4

  // log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_1B = 2'd0,
    SIZE_2B = 2'd1,
    SIZE_4B = 2'd2,
    SIZE_8B = 2'd3
  } access_size_t;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    RESP      = 3'd1,
    WB_REQ    = 3'd2,
    WB_DATA   = 3'd3,
    FILL_REQ  = 3'd4,
    FILL_DATA = 3'd5
  } ctrl_state_t;

endpackage

// File: verilog/cache_tag_store.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_tag_store (
  input  logic              clk,
  input  logic              rst,
  input  cache_pkg::index_t lookup_index_i,
  input  cache_pkg::tag_t   lookup_tag_i,
  output logic              hit_o,
  output cache_pkg::way_t   hit_way_o,
  input  cache_pkg::way_t   victim_way_i,
  output logic              victim_dirty_o,
  output cache_pkg::tag_t   victim_tag_o,
  input  logic              set_dirty_i,
  input  cache_pkg::way_t   set_way_i,
  input  logic              fill_start_i,
  input  logic              fill_done_i,
  input  cache_pkg::tag_t   fill_tag_i,
  input  logic              clean_i
);

  cache_pkg::tag_t        tags  [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid [`CACHE_WAYS];
  logic [`CACHE_SETS-1:0] dirty [`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0] way_hit;

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      way_hit[w] = valid[w][lookup_index_i] && (tags[w][lookup_index_i] == lookup_tag_i);
    end
  end

  assign hit_o = |way_hit;

  // a tag lives in one way only, so no priority question
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way_o = cache_pkg::way_t'(w);
      end
    end
  end

  assign victim_tag_o   = tags[victim_way_i][lookup_index_i];
  assign victim_dirty_o = valid[victim_way_i][lookup_index_i] &&
                          dirty[victim_way_i][lookup_index_i];

  always_ff @(posedge clk) begin
    if (fill_start_i) begin
      tags[victim_way_i][lookup_index_i] <= fill_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
    end else begin
      if (set_dirty_i) begin
        dirty[set_way_i][lookup_index_i] <= 1'b1;  // store hit
      end
      if (clean_i) begin
        dirty[victim_way_i][lookup_index_i] <= 1'b0;
      end
      // line is invalid while its refill is in flight
      if (fill_start_i) begin
        valid[victim_way_i][lookup_index_i] <= 1'b0;
      end
      if (fill_done_i) begin
        valid[victim_way_i][lookup_index_i] <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/cache_top.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rw_addr_valid_i,
  output logic                    rw_addr_ready_o,
  input  cache_pkg::addr_t        rw_addr_i,
  input  logic                    rw_we_i,
  input  cache_pkg::access_size_t rw_size_i,
  input  cache_pkg::data_t        w_data_i,
  output logic                    rw_done_o,
  output cache_pkg::data_t        r_data_o,
  output logic                    mem_req_valid_o,
  input  logic                    mem_req_ready_i,
  output cache_pkg::addr_t        mem_req_addr_o,
  output logic                    mem_req_we_o,
  output logic                    mem_w_valid_o,
  input  logic                    mem_w_ready_i,
  output cache_pkg::data_t        mem_w_data_o,
  input  logic                    mem_r_valid_i,
  output logic                    mem_r_ready_o,
  input  cache_pkg::data_t        mem_r_data_i
);

  // tag store
  cache_pkg::index_t lookup_index;
  cache_pkg::tag_t   lookup_tag;
  logic              hit;
  cache_pkg::way_t   hit_way;
  cache_pkg::way_t   victim_way;
  logic              victim_dirty;
  cache_pkg::tag_t   victim_tag;
  logic              set_dirty;
  cache_pkg::way_t   set_way;
  logic              fill_start;
  logic              fill_done;
  cache_pkg::tag_t   fill_tag;
  logic              clean;

  // data array
  logic [$clog2(`CACHE_SETS*`CACHE_ROWS_PER_LINE)-1:0] row_addr;
  cache_pkg::way_t         da_way;
  logic                    da_we;
  logic                    da_fill;
  cache_pkg::data_t        store_data;
  cache_pkg::data_t        fill_data;
  logic                    fill_half;
  cache_pkg::access_size_t da_size;
  logic [3:0]              byte_offset;
  cache_pkg::row_t         row;
  cache_pkg::data_t        load_data;

  cache_controller i_ctrl (
    .clk             (clk),
    .rst             (rst),
    .rw_addr_valid_i (rw_addr_valid_i),
    .rw_addr_ready_o (rw_addr_ready_o),
    .rw_addr_i       (rw_addr_i),
    .rw_we_i         (rw_we_i),
    .rw_size_i       (rw_size_i),
    .w_data_i        (w_data_i),
    .rw_done_o       (rw_done_o),
    .r_data_o        (r_data_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_w_valid_o   (mem_w_valid_o),
    .mem_w_ready_i   (mem_w_ready_i),
    .mem_w_data_o    (mem_w_data_o),
    .mem_r_valid_i   (mem_r_valid_i),
    .mem_r_ready_o   (mem_r_ready_o),
    .mem_r_data_i    (mem_r_data_i),
    .lookup_index_o  (lookup_index),
    .lookup_tag_o    (lookup_tag),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .victim_way_o    (victim_way),
    .victim_dirty_i  (victim_dirty),
    .victim_tag_i    (victim_tag),
    .set_dirty_o     (set_dirty),
    .set_way_o       (set_way),
    .fill_start_o    (fill_start),
    .fill_done_o     (fill_done),
    .fill_tag_o      (fill_tag),
    .clean_o         (clean),
    .row_addr_o      (row_addr),
    .way_o           (da_way),
    .we_o            (da_we),
    .fill_o          (da_fill),
    .store_data_o    (store_data),
    .fill_data_o     (fill_data),
    .fill_half_o     (fill_half),
    .size_o          (da_size),
    .byte_offset_o   (byte_offset),
    .row_i           (row),
    .load_data_i     (load_data)
  );

  cache_tag_store i_tags (
    .clk            (clk),
    .rst            (rst),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_i   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .set_dirty_i    (set_dirty),
    .set_way_i      (set_way),
    .fill_start_i   (fill_start),
    .fill_done_i    (fill_done),
    .fill_tag_i     (fill_tag),
    .clean_i        (clean)
  );

  cache_data_array i_data (
    .clk           (clk),
    .row_addr_i    (row_addr),
    .way_i         (da_way),
    .we_i          (da_we),
    .fill_i        (da_fill),
    .store_data_i  (store_data),
    .fill_data_i   (fill_data),
    .fill_half_i   (fill_half),
    .size_i        (da_size),
    .byte_offset_i (byte_offset),
    .row_o         (row),
    .load_data_o   (load_data)
  );

endmodule
